/* src/vga_defines.svh */
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

////////////////////////////////////////
// Horizontal timing, in pixel clocks
////////////////////////////////////////
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_TOTAL  800

////////////////////////////////////////
// Vertical timing, in lines
////////////////////////////////////////
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_TOTAL  525

// Sprite geometry and transparent colour
`define SPRITE_W   64
`define SPRITE_H   64
`define SPRITE_KEY 12'h000

// Register map on cfg_addr
`define REG_XPOS 2'd0
`define REG_YPOS 2'd1
`define REG_BG   2'd2
`define REG_CTRL 2'd3

`endif

/* src/vga_pkg.sv */
package vga_pkg;

  // Widths shared by every pipeline stage
  localparam int COORD_W = 12;
  localparam int RGB_W   = 12;

  typedef logic [COORD_W-1:0] coord_t;  // Counters and screen positions
  typedef logic [RGB_W-1:0]   rgb_t;    // 4 bits each of red, green, blue

  ////////////////////////////////////////
  // Sprite pixel address
  ////////////////////////////////////////
  // The drawing stage builds the address from row and column offsets,
  // while the pattern block also reads it back as one linear index.
  typedef union packed {
    logic [15:0] word;    // Linear index into the sprite
    struct packed {
      logic [7:0] row;    // Line offset inside the sprite
      logic [7:0] col;    // Pixel offset inside the line
    } rc;
  } sprite_addr_u;

endpackage

/* src/vga_timing.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module vga_timing (
  input  logic            pclk,
  input  logic            rst,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output logic            hsync,
  output logic            vsync,
  output logic            hblnk,
  output logic            vblnk,
  output logic            vsync_start
);

  localparam vga_pkg::coord_t H_LAST   = vga_pkg::coord_t'(`H_TOTAL - 1);
  localparam vga_pkg::coord_t V_LAST   = vga_pkg::coord_t'(`V_TOTAL - 1);
  localparam vga_pkg::coord_t H_ACT    = vga_pkg::coord_t'(`H_ACTIVE);
  localparam vga_pkg::coord_t V_ACT    = vga_pkg::coord_t'(`V_ACTIVE);
  localparam vga_pkg::coord_t HS_START = vga_pkg::coord_t'(`H_ACTIVE + `H_FRONT);
  localparam vga_pkg::coord_t HS_END   = vga_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam vga_pkg::coord_t VS_START = vga_pkg::coord_t'(`V_ACTIVE + `V_FRONT);
  localparam vga_pkg::coord_t VS_END   = vga_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

  vga_pkg::coord_t hcount_nxt;
  vga_pkg::coord_t vcount_nxt;

  ////////////////////////////////////////
  // Next counter values
  ////////////////////////////////////////
  always_comb begin
    hcount_nxt = hcount + 1'b1;
    vcount_nxt = vcount;
    if (hcount == H_LAST) begin
      hcount_nxt = '0;                   // End of line
      if (vcount == V_LAST) begin
        vcount_nxt = '0;                 // End of frame
      end else begin
        vcount_nxt = vcount + 1'b1;
      end
    end
  end

  // Sync and blanking are decoded from the next count so that they
  // leave this block in step with the registered counters
  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount      <= '0;
      vcount      <= '0;
      hsync       <= 1'b0;
      vsync       <= 1'b0;
      hblnk       <= 1'b0;
      vblnk       <= 1'b0;
      vsync_start <= 1'b0;
    end else begin
      hcount      <= hcount_nxt;
      vcount      <= vcount_nxt;
      hsync       <= (hcount_nxt >= HS_START) && (hcount_nxt < HS_END);  // Active high
      vsync       <= (vcount_nxt >= VS_START) && (vcount_nxt < VS_END);
      hblnk       <= hcount_nxt >= H_ACT;
      vblnk       <= vcount_nxt >= V_ACT;
      vsync_start <= (vcount_nxt == VS_START) && (hcount_nxt == '0);  // First sync cycle
    end
  end

  a_count_range: assert property (
    @(posedge pclk) disable iff (rst)
    (hcount < vga_pkg::coord_t'(`H_TOTAL)) && (vcount < vga_pkg::coord_t'(`V_TOTAL))
  ) else $error("Timing counter outside its total");

endmodule

/* src/overlay_regs.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module overlay_regs (
  input  logic            pclk,
  input  logic            rst,
  input  logic            cfg_we,
  input  logic [1:0]      cfg_addr,
  input  logic [11:0]     cfg_wdata,
  input  logic            vsync_start,
  output vga_pkg::coord_t xpos,
  output vga_pkg::coord_t ypos,
  output vga_pkg::rgb_t   bg_color,
  output logic            game_on
);

  vga_pkg::coord_t xpos_pend;
  vga_pkg::coord_t ypos_pend;
  vga_pkg::rgb_t   bg_pend;
  logic            game_on_pend;

  ////////////////////////////////////////
  // Pending copies, written by the bus
  ////////////////////////////////////////
  always_ff @(posedge pclk) begin
    if (rst) begin
      xpos_pend    <= '0;
      ypos_pend    <= '0;
      bg_pend      <= '0;
      game_on_pend <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_addr)
        `REG_XPOS: xpos_pend    <= cfg_wdata;
        `REG_YPOS: ypos_pend    <= cfg_wdata;
        `REG_BG:   bg_pend      <= cfg_wdata;
        `REG_CTRL: game_on_pend <= cfg_wdata[0];  // Enable bit
        default:   ;
      endcase
    end
  end

  // Active copies move only at the start of vertical sync
  always_ff @(posedge pclk) begin
    if (rst) begin
      xpos     <= '0;
      ypos     <= '0;
      bg_color <= '0;
      game_on  <= 1'b0;
    end else if (vsync_start) begin
      xpos     <= xpos_pend;
      ypos     <= ypos_pend;
      bg_color <= bg_pend;
      game_on  <= game_on_pend;
    end
  end

  a_addr_known: assert property (
    @(posedge pclk) disable iff (rst) cfg_we |-> !$isunknown(cfg_addr)
  ) else $error("Register write with unknown address");

endmodule

/* src/draw_background.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module draw_background (
  input  logic            pclk,
  input  logic            rst,
  input  vga_pkg::coord_t hcount_in,
  input  vga_pkg::coord_t vcount_in,
  input  logic            hsync_in,
  input  logic            vsync_in,
  input  logic            hblnk_in,
  input  logic            vblnk_in,
  input  vga_pkg::rgb_t   bg_color,
  output vga_pkg::coord_t hcount_out,
  output vga_pkg::coord_t vcount_out,
  output logic            hsync_out,
  output logic            vsync_out,
  output logic            hblnk_out,
  output logic            vblnk_out,
  output vga_pkg::rgb_t   rgb_out
);

  localparam vga_pkg::coord_t H_LAST = vga_pkg::coord_t'(`H_ACTIVE - 1);
  localparam vga_pkg::coord_t V_LAST = vga_pkg::coord_t'(`V_ACTIVE - 1);

  vga_pkg::rgb_t rgb_nxt;
  logic          on_border;

  assign on_border = (hcount_in == '0) || (hcount_in == H_LAST) ||
                     (vcount_in == '0) || (vcount_in == V_LAST);

  always_comb begin
    if (hblnk_in || vblnk_in) begin
      rgb_nxt = 12'h000;                 // Black while blanking
    end else if (on_border) begin
      rgb_nxt = 12'hfff;                 // One pixel white frame
    end else begin
      rgb_nxt = bg_color;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

endmodule

/* src/sprite_pattern.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module sprite_pattern (
  input  vga_pkg::sprite_addr_u pixel_addr,
  output vga_pkg::rgb_t         rgb_pixel
);

  localparam logic [7:0] LAST_ROW = 8'(`SPRITE_H - 1);
  localparam logic [7:0] LAST_COL = 8'(`SPRITE_W - 1);

  logic [7:0] row;
  logic [7:0] col;
  logic       edge_hit;
  logic       odd_cell;

  assign row = pixel_addr.rc.row;
  assign col = pixel_addr.rc.col;

  assign edge_hit = (row == 8'd0) || (row == LAST_ROW) ||
                    (col == 8'd0) || (col == LAST_COL);
  assign odd_cell = row[3] ^ col[3];     // 8x8 cell parity

  ////////////////////////////////////////
  // Ringed sprite image
  ////////////////////////////////////////
  always_comb begin
    if (edge_hit) begin
      rgb_pixel = 12'hf00;               // Red outline
    end else if (odd_cell) begin
      rgb_pixel = `SPRITE_KEY;           // See-through cell
    end else begin
      // Green cell with blue ramping along the linear index
      rgb_pixel = {4'h0, 4'hf, pixel_addr.word[3:0]};
    end
  end

endmodule

/* src/draw_sprite.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module draw_sprite (
  input  logic                  pclk,
  input  logic                  rst,
  input  vga_pkg::coord_t       hcount_in,
  input  vga_pkg::coord_t       vcount_in,
  input  logic                  hsync_in,
  input  logic                  vsync_in,
  input  logic                  hblnk_in,
  input  logic                  vblnk_in,
  input  vga_pkg::rgb_t         rgb_in,
  input  vga_pkg::coord_t       xpos,
  input  vga_pkg::coord_t       ypos,
  input  logic                  game_on,
  input  vga_pkg::rgb_t         rgb_pixel,
  output vga_pkg::coord_t       hcount_out,
  output vga_pkg::coord_t       vcount_out,
  output logic                  hsync_out,
  output logic                  vsync_out,
  output logic                  hblnk_out,
  output logic                  vblnk_out,
  output vga_pkg::rgb_t         rgb_out,
  output vga_pkg::sprite_addr_u pixel_addr
);

  localparam logic IDLE = 1'b0;
  localparam logic DRAW = 1'b1;

  localparam vga_pkg::coord_t SPR_W = vga_pkg::coord_t'(`SPRITE_W);
  localparam vga_pkg::coord_t SPR_H = vga_pkg::coord_t'(`SPRITE_H);

  logic          state;
  logic          state_nxt;
  logic          in_box;
  vga_pkg::rgb_t rgb_nxt;

  ////////////////////////////////////////
  // Sprite window and pattern address
  ////////////////////////////////////////
  assign in_box = (hcount_in >= xpos) && (hcount_in < xpos + SPR_W) &&
                  (vcount_in >= ypos) && (vcount_in < ypos + SPR_H);  // Exclusive bounds

  always_comb begin
    pixel_addr.rc.row = 8'(vcount_in - ypos);
    pixel_addr.rc.col = 8'(hcount_in - xpos);
  end

  ////////////////////////////////////////
  // Enable state and colour select
  ////////////////////////////////////////
  always_comb begin
    state_nxt = game_on ? DRAW : IDLE;   // Lags game_on by one cycle
    rgb_nxt   = rgb_in;
    case (state)
      IDLE: rgb_nxt = rgb_in;
      DRAW: begin
        if (in_box && (rgb_pixel != `SPRITE_KEY)) begin
          rgb_nxt = rgb_pixel;
        end
      end
      default: rgb_nxt = rgb_in;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state      <= IDLE;
      hcount_out <= '0;
      vcount_out <= '0;
      hsync_out  <= 1'b0;
      vsync_out  <= 1'b0;
      hblnk_out  <= 1'b0;
      vblnk_out  <= 1'b0;
      rgb_out    <= '0;
    end else begin
      state      <= state_nxt;
      hcount_out <= hcount_in;
      vcount_out <= vcount_in;
      hsync_out  <= hsync_in;
      vsync_out  <= vsync_in;
      hblnk_out  <= hblnk_in;
      vblnk_out  <= vblnk_in;
      rgb_out    <= rgb_nxt;
    end
  end

  // Background blanks to black and the sprite never reaches the blanking area
  a_black_in_blank: assert property (
    @(posedge pclk) disable iff (rst) (hblnk_out || vblnk_out) |-> (rgb_out == '0)
  ) else $error("Colour present during blanking");

endmodule

/* src/vga_top.sv */
`timescale 1ns/1ns

module vga_top (
  input  logic            pclk,
  input  logic            rst,
  input  logic            cfg_we,
  input  logic [1:0]      cfg_addr,
  input  logic [11:0]     cfg_wdata,
  output logic            hsync,
  output logic            vsync,
  output logic            hblnk,
  output logic            vblnk,
  output vga_pkg::coord_t hcount,
  output vga_pkg::coord_t vcount,
  output vga_pkg::rgb_t   rgb
);

  // Timing generator outputs
  vga_pkg::coord_t tim_hcount;
  vga_pkg::coord_t tim_vcount;
  logic            tim_hsync;
  logic            tim_vsync;
  logic            tim_hblnk;
  logic            tim_vblnk;
  logic            vsync_start;

  // Active register values
  vga_pkg::coord_t xpos;
  vga_pkg::coord_t ypos;
  vga_pkg::rgb_t   bg_color;
  logic            game_on;

  // Background stage outputs
  vga_pkg::coord_t bg_hcount;
  vga_pkg::coord_t bg_vcount;
  logic            bg_hsync;
  logic            bg_vsync;
  logic            bg_hblnk;
  logic            bg_vblnk;
  vga_pkg::rgb_t   bg_rgb;

  // Sprite image lookup
  vga_pkg::sprite_addr_u pixel_addr;
  vga_pkg::rgb_t         rgb_pixel;

  vga_timing u_vga_timing (
    .pclk        (pclk),
    .rst         (rst),
    .hcount      (tim_hcount),
    .vcount      (tim_vcount),
    .hsync       (tim_hsync),
    .vsync       (tim_vsync),
    .hblnk       (tim_hblnk),
    .vblnk       (tim_vblnk),
    .vsync_start (vsync_start)
  );

  overlay_regs u_overlay_regs (
    .pclk        (pclk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .vsync_start (vsync_start),
    .xpos        (xpos),
    .ypos        (ypos),
    .bg_color    (bg_color),
    .game_on     (game_on)
  );

  draw_background u_draw_background (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (tim_hcount),
    .vcount_in  (tim_vcount),
    .hsync_in   (tim_hsync),
    .vsync_in   (tim_vsync),
    .hblnk_in   (tim_hblnk),
    .vblnk_in   (tim_vblnk),
    .bg_color   (bg_color),
    .hcount_out (bg_hcount),
    .vcount_out (bg_vcount),
    .hsync_out  (bg_hsync),
    .vsync_out  (bg_vsync),
    .hblnk_out  (bg_hblnk),
    .vblnk_out  (bg_vblnk),
    .rgb_out    (bg_rgb)
  );

  draw_sprite u_draw_sprite (
    .pclk       (pclk),
    .rst        (rst),
    .hcount_in  (bg_hcount),
    .vcount_in  (bg_vcount),
    .hsync_in   (bg_hsync),
    .vsync_in   (bg_vsync),
    .hblnk_in   (bg_hblnk),
    .vblnk_in   (bg_vblnk),
    .rgb_in     (bg_rgb),
    .xpos       (xpos),
    .ypos       (ypos),
    .game_on    (game_on),
    .rgb_pixel  (rgb_pixel),
    .hcount_out (hcount),
    .vcount_out (vcount),
    .hsync_out  (hsync),
    .vsync_out  (vsync),
    .hblnk_out  (hblnk),
    .vblnk_out  (vblnk),
    .rgb_out    (rgb),
    .pixel_addr (pixel_addr)
  );

  sprite_pattern u_sprite_pattern (
    .pixel_addr (pixel_addr),
    .rgb_pixel  (rgb_pixel)
  );

endmodule

/* verification/vga_tb.sv */
`timescale 1ns/1ns
`include "vga_defines.svh"

module vga_tb;

  localparam int CLK_HALF     = 2;                   // 4 ns pixel clock
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int TEST_LINE    = 100;                 // Mid-frame write point
  localparam int WATCHDOG_NS  = (5 * FRAME_CYCLES + 40 * `H_TOTAL) * 2 * CLK_HALF;
  localparam int ERROR_PRINTS = 20;

  logic            pclk;
  logic            rst;
  logic            cfg_we;
  logic [1:0]      cfg_addr;
  logic [11:0]     cfg_wdata;
  logic            hsync;
  logic            vsync;
  logic            hblnk;
  logic            vblnk;
  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;
  vga_pkg::rgb_t   rgb;

  // Register model, pending and active
  vga_pkg::coord_t pend_xpos;
  vga_pkg::coord_t pend_ypos;
  vga_pkg::rgb_t   pend_bg;
  logic            pend_on;
  vga_pkg::coord_t act_xpos;
  vga_pkg::coord_t act_ypos;
  vga_pkg::rgb_t   act_bg;
  logic            act_on;

  logic [31:0]     lfsr_state;
  int              errors;
  int              checked;
  int              sprite_hits;
  int              warmup;
  logic            prev_valid;
  logic            vsync_prev;
  int              prev_h;
  int              prev_v;

  vga_top dut_i (
    .pclk      (pclk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .hsync     (hsync),
    .vsync     (vsync),
    .hblnk     (hblnk),
    .vblnk     (vblnk),
    .hcount    (hcount),
    .vcount    (vcount),
    .rgb       (rgb)
  );

  always #(CLK_HALF) pclk = ~pclk;

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////
  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'hd000_0001;  // Galois taps 32,31,29,1
    end
    return lsb;
  endfunction

  function automatic logic [11:0] random_coord(input int max_val, input int nbits);
    int value;
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      value = (value << 1) | (lfsr_bit() ? 1 : 0);
    end
    return 12'(value % (max_val + 1));
  endfunction

  function automatic vga_pkg::rgb_t expected_rgb(input int h, input int v);
    vga_pkg::rgb_t color;
    int            row;
    int            col;
    if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
      return 12'h000;                          // Blanking
    end
    if (h == 0 || h == `H_ACTIVE - 1 || v == 0 || v == `V_ACTIVE - 1) begin
      color = 12'hfff;
    end else begin
      color = act_bg;
    end
    row = v - int'(act_ypos);
    col = h - int'(act_xpos);
    if (act_on && row >= 0 && row < `SPRITE_H && col >= 0 && col < `SPRITE_W) begin
      if (row == 0 || row == `SPRITE_H - 1 || col == 0 || col == `SPRITE_W - 1) begin
        color = 12'hf00;                       // Outline
      end else if (((row / 8) % 2) == ((col / 8) % 2)) begin
        color = {8'h0f, 4'(col % 16)};         // Opaque cell, else background shows
      end
    end
    return color;
  endfunction

  task automatic report_error(input string msg);
    if (errors < ERROR_PRINTS) begin
      $display("** Error at %0t ns: %s", $time, msg);
    end
    errors++;
  endtask

  task automatic check_timing(input int h, input int v);
    logic [3:0] exp_flags;
    int         next_h;
    int         next_v;
    exp_flags[3] = (h >= `H_ACTIVE + `H_FRONT) && (h < `H_ACTIVE + `H_FRONT + `H_SYNC);
    exp_flags[2] = (v >= `V_ACTIVE + `V_FRONT) && (v < `V_ACTIVE + `V_FRONT + `V_SYNC);
    exp_flags[1] = h >= `H_ACTIVE;
    exp_flags[0] = v >= `V_ACTIVE;
    if ({hsync, vsync, hblnk, vblnk} !== exp_flags) begin
      report_error($sformatf("sync/blank %b, expected %b at (%0d,%0d)",
                             {hsync, vsync, hblnk, vblnk}, exp_flags, h, v));
    end
    if (prev_valid) begin
      next_h = (prev_h == `H_TOTAL - 1) ? 0 : prev_h + 1;
      next_v = prev_v;
      if (prev_h == `H_TOTAL - 1) begin
        next_v = (prev_v == `V_TOTAL - 1) ? 0 : prev_v + 1;
      end
      if (h != next_h || v != next_v) begin
        report_error($sformatf("counters (%0d,%0d), expected (%0d,%0d)",
                               h, v, next_h, next_v));
      end
    end
    prev_h     = h;
    prev_v     = v;
    prev_valid = 1'b1;
  endtask

  ////////////////////////////////////////
  // Pixel compare, on the falling edge
  ////////////////////////////////////////
  always @(negedge pclk) begin : compare
    vga_pkg::rgb_t exp_rgb;
    if (!rst) begin
      if (warmup >= 2) begin                  // Reset values still in the pipe before
        check_timing(int'(hcount), int'(vcount));
        exp_rgb = expected_rgb(int'(hcount), int'(vcount));
        checked++;
        if (rgb !== exp_rgb) begin
          report_error($sformatf("rgb %h, expected %h at (%0d,%0d)",
                                 rgb, exp_rgb, hcount, vcount));
        end
        if (act_on && rgb == exp_rgb && (exp_rgb == 12'hf00 || exp_rgb[11:4] == 8'h0f)) begin
          sprite_hits++;
        end
        if (vsync && !vsync_prev) begin
          act_xpos = pend_xpos;               // Shadow copy at vsync start
          act_ypos = pend_ypos;
          act_bg   = pend_bg;
          act_on   = pend_on;
        end
      end
      warmup++;
      vsync_prev = vsync;
    end
  end

  task automatic write_reg(input logic [1:0] addr, input logic [11:0] data);
    @(posedge pclk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    case (addr)
      `REG_XPOS: pend_xpos = data;
      `REG_YPOS: pend_ypos = data;
      `REG_BG:   pend_bg   = data;
      default:   pend_on   = data[0];
    endcase
    @(posedge pclk);
    cfg_we <= 1'b0;
  endtask

  task automatic wait_line(input int line);
    do begin
      @(negedge pclk);
    end while (!(int'(vcount) == line && hcount == '0));
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, frames did not complete", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    pclk       = 1'b0;
    rst        = 1'b1;
    cfg_we     = 1'b0;
    cfg_addr   = 2'd0;
    cfg_wdata  = 12'h000;
    lfsr_state = 32'hbcf9_6600;
    {pend_xpos, pend_ypos, pend_bg, pend_on} = '0;
    {act_xpos, act_ypos, act_bg, act_on}     = '0;
    errors      = 0;
    checked     = 0;
    sprite_hits = 0;
    warmup      = 0;
    prev_valid  = 1'b0;
    vsync_prev  = 1'b0;
    repeat (2) @(posedge pclk);
    rst <= 1'b0;
    @(negedge pclk);                           // DUT has not yet seen reset low
    if ({hsync, vsync, hblnk, vblnk} !== 4'b0 || rgb !== 12'h000) begin
      report_error("outputs not cleared by reset");
    end
    wait_line(TEST_LINE);                      // Frame 0
    write_reg(`REG_BG, 12'h248);
    wait_line(TEST_LINE);                      // Frame 1, background only
    write_reg(`REG_XPOS, random_coord(`H_ACTIVE - `SPRITE_W, 10));
    write_reg(`REG_YPOS, random_coord(`V_ACTIVE - `SPRITE_H, 9));
    write_reg(`REG_CTRL, 12'h001);
    wait_line(TEST_LINE);                      // Frame 2, sprite on
    write_reg(`REG_XPOS, random_coord(`H_ACTIVE - `SPRITE_W, 10));
    write_reg(`REG_YPOS, random_coord(`V_ACTIVE - `SPRITE_H, 9));
    write_reg(`REG_BG, 12'h731);
    wait_line(TEST_LINE);                      // Frame 3, moved sprite
    write_reg(`REG_CTRL, 12'h000);
    wait_line(TEST_LINE);                      // Frame 4, sprite removed
    wait_line(`V_ACTIVE);
    if (sprite_hits == 0) begin
      $display("The sprite never appeared on screen");
      errors++;
    end
    $display("Checked %0d pixels, %0d sprite pixels, %0d errors", checked, sprite_hits, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/vga_pkg.sv
src/vga_timing.sv
src/overlay_regs.sv
src/draw_background.sv
src/sprite_pattern.sv
src/draw_sprite.sv
src/vga_top.sv
verification/vga_tb.sv

/* run.sh */
#!/bin/sh
# Compile the VGA pipeline testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
    --top-module vga_tb -f verilog.f -o vga_sim &&
  ./obj_dir/vga_sim > sim.log 2>&1 &&
  cat sim.log &&
  ! grep -q "Test failed" sim.log ||
  { [ -f sim.log ] && cat sim.log; echo "Simulation did not pass"; exit 1; }

echo "Simulation passed"
